/* rtl/merge_config.svh */
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// Width of one data word, zero is reserved as the end-of-run marker
`define MERGE_DATA_W 16

// Entries per input FIFO, must stay a power of two
`define MERGE_FIFO_DEPTH 8

`endif

/* rtl/merge_control.sv */
`timescale 1ns/1ps
`default_nettype none

module merge_control (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_a_empty,
   input  logic i_b_empty,
   input  logic i_a_zero,
   input  logic i_b_zero,
   input  logic i_a_lte_b,
   input  logic i_out_hold,
   input  logic i_end,
   output logic o_pop_a,
   output logic o_pop_b,
   output logic o_sel_a,
   output logic o_emit,
   output logic o_done
);
   import merge_pkg::*;

   merge_state_e state;
   merge_state_e next_state;
   logic         head_missing;
   logic         stall;

   // Only the heads that the current state looks at can stall it
   always_comb begin
      case (state)
         ST_A_DONE: head_missing = i_b_empty;
         ST_B_DONE: head_missing = i_a_empty;
         ST_FINISHED: head_missing = 1'b0;
         default: head_missing = i_a_empty || i_b_empty;
      endcase
   end

   assign stall = i_out_hold || head_missing;

   always_comb begin
      next_state = state;
      o_pop_a    = 1'b0;
      o_pop_b    = 1'b0;
      o_sel_a    = 1'b1;
      o_emit     = 1'b0;
      case (state)
         ST_MERGE: begin
            if (i_a_empty && i_b_empty && i_end && !i_out_hold) begin
               next_state = ST_FINISHED;   // Drained on a run boundary
            end else if (!stall) begin
               if (i_a_zero) begin
                  next_state = ST_A_DONE;
               end else if (i_b_zero) begin
                  next_state = ST_B_DONE;
               end else begin
                  o_sel_a = i_a_lte_b;
                  o_pop_a = i_a_lte_b;
                  o_pop_b = !i_a_lte_b;
                  o_emit  = 1'b1;
               end
            end
         end
         ST_A_DONE: begin
            o_sel_a = 1'b0;
            if (!stall) begin
               if (i_b_zero) begin
                  next_state = ST_BOUNDARY;
               end else begin
                  o_pop_b = 1'b1;
                  o_emit  = 1'b1;
               end
            end
         end
         ST_B_DONE: begin
            if (!stall) begin
               if (i_a_zero) begin
                  next_state = ST_BOUNDARY;
               end else begin
                  o_pop_a = 1'b1;
                  o_emit  = 1'b1;
               end
            end
         end
         ST_BOUNDARY: begin
            // Both terminators leave together as one zero
            if (!stall) begin
               o_pop_a    = 1'b1;
               o_pop_b    = 1'b1;
               o_emit     = 1'b1;
               next_state = ST_MERGE;
            end
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= ST_MERGE;
      end else begin
         state <= next_state;
      end
   end

   assign o_done = (state == ST_FINISHED);

   a_pop_a_ok : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_pop_a |-> !i_a_empty)
      else $error("merge_control: pop of empty A");

   a_pop_b_ok : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_pop_b |-> !i_b_empty)
      else $error("merge_control: pop of empty B");

   // Every emitted word consumes exactly the heads it came from
   a_emit_pops : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_emit |-> ((state == ST_BOUNDARY) ? (o_pop_a && o_pop_b) : (o_pop_a ^ o_pop_b)))
      else $error("merge_control: emit without matching pops");

endmodule

`default_nettype wire

/* rtl/merge_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module merge_datapath (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  merge_pkg::word_t i_a_head,
   input  merge_pkg::word_t i_b_head,
   input  logic             i_sel_a,
   input  logic             i_emit,
   output logic             o_a_zero,
   output logic             o_b_zero,
   output logic             o_a_lte_b,
   output merge_pkg::word_t o_out_data,
   output logic             o_out_valid
);
   import merge_pkg::*;

   word_t sel_word;
   word_t last_word;
   logic  in_run;

   assign o_a_zero  = (i_a_head == '0);
   assign o_b_zero  = (i_b_head == '0);
   assign o_a_lte_b = (i_a_head <= i_b_head);   // Ties go to A

   assign sel_word = i_sel_a ? i_a_head : i_b_head;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_out_valid <= 1'b0;
      end else begin
         o_out_valid <= i_emit;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_emit) begin
         o_out_data <= sel_word;
      end
   end

   // Track the previous output word to check run order
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         in_run <= 1'b0;
      end else if (o_out_valid) begin
         in_run <= (o_out_data != '0);   // A zero closes the run
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_out_valid) begin
         last_word <= o_out_data;
      end
   end

   // Sorted inputs and correct selection keep each output run ascending
   a_run_sorted : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_out_valid && in_run && (o_out_data != '0)) |-> (o_out_data >= last_word))
      else $error("merge_datapath: output run out of order");

endmodule

`default_nettype wire

/* rtl/merge_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "merge_config.svh"

module merge_fifo (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_push,
   input  merge_pkg::word_t     i_data,
   input  logic                 i_pop,
   output merge_pkg::word_t     o_head,
   output logic                 o_empty,
   output logic                 o_full,
   output merge_pkg::fifo_cnt_t o_count
);
   import merge_pkg::*;

   localparam int ADDR_W = $clog2(`MERGE_FIFO_DEPTH);

   word_t             mem [`MERGE_FIFO_DEPTH];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   fifo_cnt_t         count;
   logic              do_push;
   logic              do_pop;

   assign do_push = i_push && !o_full;   // A push into a full FIFO is lost
   assign do_pop  = i_pop && !o_empty;

   assign o_empty = (count == '0);
   assign o_full  = (count == fifo_cnt_t'(`MERGE_FIFO_DEPTH));
   assign o_count = count;

   // Head is read straight from the array so it falls through
   assign o_head = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;   // Pointers wrap on their own
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // The sender paces itself on the full flag
   a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_push && o_full))
      else $error("merge_fifo: push while full, word dropped");

   // Control only pops a head it has seen
   a_no_underflow : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_pop && o_empty))
      else $error("merge_fifo: pop while empty");

endmodule

`default_nettype wire

/* rtl/merge_pkg.sv */
`default_nettype none

`include "merge_config.svh"

package merge_pkg;

   // A data word, zero terminates a run
   typedef logic [`MERGE_DATA_W-1:0] word_t;

   // Fill count needs one extra bit to hold the full value
   typedef logic [$clog2(`MERGE_FIFO_DEPTH):0] fifo_cnt_t;

   typedef enum logic [2:0] {
      ST_MERGE,     // Both runs still open
      ST_A_DONE,    // A run ended, draining B
      ST_B_DONE,    // B run ended, draining A
      ST_BOUNDARY,  // Both terminators at the heads
      ST_FINISHED
   } merge_state_e;

endpackage

`default_nettype wire

/* rtl/merge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module merge_top (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  logic             i_a_push,
   input  logic             i_b_push,
   input  logic             i_end,
   input  logic             i_out_hold,
   input  merge_pkg::word_t i_a_data,
   input  merge_pkg::word_t i_b_data,
   output logic             o_a_full,
   output logic             o_b_full,
   output logic             o_out_valid,
   output logic             o_done,
   output merge_pkg::word_t o_out_data
);
   import merge_pkg::*;

   word_t     a_head;
   word_t     b_head;
   logic      a_empty;
   logic      b_empty;
   logic      a_zero;
   logic      b_zero;
   logic      a_lte_b;
   logic      pop_a;
   logic      pop_b;
   logic      sel_a;
   logic      emit;

   merge_fifo u_fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (i_a_push),
      .i_data  (i_a_data),
      .i_pop   (pop_a),
      .o_head  (a_head),
      .o_empty (a_empty),
      .o_full  (o_a_full),
      .o_count ()
   );

   merge_fifo u_fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (i_b_push),
      .i_data  (i_b_data),
      .i_pop   (pop_b),
      .o_head  (b_head),
      .o_empty (b_empty),
      .o_full  (o_b_full),
      .o_count ()
   );

   merge_datapath u_datapath (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_head    (a_head),
      .i_b_head    (b_head),
      .i_sel_a     (sel_a),
      .i_emit      (emit),
      .o_a_zero    (a_zero),
      .o_b_zero    (b_zero),
      .o_a_lte_b   (a_lte_b),
      .o_out_data  (o_out_data),
      .o_out_valid (o_out_valid)
   );

   merge_control u_control (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_a_empty  (a_empty),
      .i_b_empty  (b_empty),
      .i_a_zero   (a_zero),
      .i_b_zero   (b_zero),
      .i_a_lte_b  (a_lte_b),
      .i_out_hold (i_out_hold),
      .i_end      (i_end),
      .o_pop_a    (pop_a),
      .o_pop_b    (pop_b),
      .o_sel_a    (sel_a),
      .o_emit     (emit),
      .o_done     (o_done)
   );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the merge testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_merge -f vlog.f -o tb_merge_sim \
   && out="$(./obj_dir/tb_merge_sim)" \
   && echo "$out" \
   && echo "$out" | grep -qF ">>> PASS" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

/* tests/tb_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "merge_config.svh"

module tb_merge;
   import merge_pkg::*;

   localparam int NROWS = 6;
   localparam int MAX_W = 10;

   // Per row the A stream then the B stream with a zero closing each run
   int tbl [NROWS][2][MAX_W] = '{
      '{'{1, 4, 7, 0, 0, 0, 0, 0, 0, 0},
        '{2, 5, 8, 0, 0, 0, 0, 0, 0, 0}},
      '{'{3, 0, 2, 5, 9, 11, 0, 0, 0, 0},
        '{1, 4, 6, 8, 0, 7, 0, 0, 0, 0}},
      '{'{5, 5, 9, 0, 0, 0, 0, 0, 0, 0},
        '{5, 9, 9, 0, 0, 0, 0, 0, 0, 0}},
      '{'{2, 3, 10, 20, 0, 1, 0, 0, 0, 0},
        '{1, 15, 16, 0, 4, 6, 0, 0, 0, 0}},
      '{'{1, 0, 8, 0, 3, 4, 0, 0, 0, 0},
        '{2, 0, 0, 5, 0, 0, 0, 0, 0, 0}},
      '{'{1, 2, 3, 4, 5, 6, 7, 8, 9, 0},
        '{6, 0, 0, 0, 0, 0, 0, 0, 0, 0}}
   };
   int len [NROWS][2] = '{'{4, 4}, '{7, 7}, '{4, 4}, '{7, 7}, '{7, 5}, '{10, 2}};
   int hold_mode [NROWS] = '{0, 0, 0, 1, 1, 2};   // Mode 2 holds long enough for A to fill

   logic         clk;
   logic         rst_n;
   logic         push [2];
   word_t        data [2];
   logic         full [2];
   logic         input_end;
   logic         out_hold;
   logic         out_valid;
   logic         done;
   word_t        out_data;
   merge_state_e ctl_state;
   word_t        exp_q [$];
   int           seed;
   int           word_errs;
   int           done_errs;
   int           full_errs;
   int           other_errs;
   int           cycle_cnt = 0;
   int           cycle_limit;
   bit           saw_a_full;

   merge_top UUT (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_a_push    (push[0]),
      .i_b_push    (push[1]),
      .i_end       (input_end),
      .i_out_hold  (out_hold),
      .i_a_data    (data[0]),
      .i_b_data    (data[1]),
      .o_a_full    (full[0]),
      .o_b_full    (full[1]),
      .o_out_valid (out_valid),
      .o_done      (done),
      .o_out_data  (out_data)
   );

   assign ctl_state = UUT.u_control.state;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles with the FSM in %s", cycle_cnt, ctl_state.name());
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic check_word(input string name, input word_t got, input word_t want);
      if (got !== want) begin
         word_errs++;
         $display("ERROR at time %0t: %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_done(input string name, input logic got, input logic want);
      if (got !== want) begin
         done_errs++;
         $display("ERROR at time %0t: %s got %b expected %b", $time, name, got, want);
      end
   endtask

   task automatic check_full(input string name, input logic got, input logic want);
      if (got !== want) begin
         full_errs++;
         $display("ERROR at time %0t: %s got %b expected %b", $time, name, got, want);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      push[0] = 1'b0;
      push[1] = 1'b0;
      input_end = 1'b0;
      out_hold = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   // Stable two-way merge of each run pair with one zero after every output run
   task automatic build_expected(input int row);
      word_t run_a [$];
      word_t run_b [$];
      int    ia;
      int    ib;
      ia = 0;
      ib = 0;
      exp_q.delete();
      while (ia < len[row][0]) begin
         while (tbl[row][0][ia] != 0) begin
            run_a.push_back(word_t'(tbl[row][0][ia]));
            ia++;
         end
         while (tbl[row][1][ib] != 0) begin
            run_b.push_back(word_t'(tbl[row][1][ib]));
            ib++;
         end
         ia++;
         ib++;
         while (run_a.size() != 0 && run_b.size() != 0) begin
            if (run_a[0] <= run_b[0]) begin   // A wins a tie
               exp_q.push_back(run_a.pop_front());
            end else begin
               exp_q.push_back(run_b.pop_front());
            end
         end
         while (run_a.size() != 0) begin
            exp_q.push_back(run_a.pop_front());
         end
         while (run_b.size() != 0) begin
            exp_q.push_back(run_b.pop_front());
         end
         exp_q.push_back('0);
      end
   endtask

   task automatic push_stream(input int row, input int side);
      int    i;
      string name;
      i = 0;
      name = (side == 0) ? "o_a_full" : "o_b_full";
      while (i < len[row][side]) begin
         @(posedge clk);
         #1;
         push[side] = 1'b0;
         if (i < `MERGE_FIFO_DEPTH) begin
            check_full(name, full[side], 1'b0);   // Fewer words pushed than the FIFO holds
         end
         if (full[side]) begin
            saw_a_full = saw_a_full || (side == 0);
         end else if (($random(seed) & 3) != 0) begin   // Random gaps between pushes
            data[side] = word_t'(tbl[row][side][i]);
            push[side] = 1'b1;
            i++;
         end
      end
      @(posedge clk);
      #1;
      push[side] = 1'b0;
   endtask

   task automatic drive_hold(input int mode);
      out_hold = (mode == 2);
      if (mode == 2) begin
         repeat (4 * `MERGE_FIFO_DEPTH) @(posedge clk);
      end
      while (!done) begin
         @(posedge clk);
         #1;
         out_hold = (mode != 0) && (($random(seed) & 3) == 0);
      end
      out_hold = 1'b0;
   endtask

   task automatic watch_outputs();
      do begin
         @(negedge clk);
         if (out_valid && exp_q.size() == 0) begin
            other_errs++;
            $display("Extra output word %h appeared at time %0t", out_data, $time);
         end else if (out_valid) begin
            check_word("o_out_data", out_data, exp_q.pop_front());
         end
         if (exp_q.size() != 0 || !input_end) begin
            check_done("o_done", done, 1'b0);   // Done only after the last output
         end
      end while (!done);
   endtask

   initial begin
      seed = 32'h6e32_1ab4;
      word_errs = 0;
      done_errs = 0;
      full_errs = 0;
      other_errs = 0;
      rst_n = 1'b0;
      push[0] = 1'b0;
      push[1] = 1'b0;
      data[0] = '0;
      data[1] = '0;
      input_end = 1'b0;
      out_hold = 1'b0;
      cycle_limit = 200;
      for (int r = 0; r < NROWS; r++) begin
         cycle_limit += 40 * (len[r][0] + len[r][1]);
      end
      for (int r = 0; r < NROWS; r++) begin
         apply_reset();
         build_expected(r);
         saw_a_full = 1'b0;
         fork
            begin
               fork
                  push_stream(r, 0);
                  push_stream(r, 1);
               join
               input_end = 1'b1;
            end
            drive_hold(hold_mode[r]);
            watch_outputs();
         join
         if (exp_q.size() != 0) begin
            other_errs++;
            $display("Row %0d finished with %0d expected words missing", r, exp_q.size());
         end
         if (hold_mode[r] == 2 && !saw_a_full) begin
            other_errs++;
            $display("Row %0d never saw the A FIFO report full", r);
         end
      end
      $display("Errors: %0d data, %0d done, %0d full, %0d other",
               word_errs, done_errs, full_errs, other_errs);
      if (word_errs + done_errs + full_errs + other_errs == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/merge_pkg.sv
rtl/merge_fifo.sv
rtl/merge_datapath.sv
rtl/merge_control.sv
rtl/merge_top.sv
tests/tb_merge.sv
